// ==== rtl/lc4_isa_pkg.sv ====
//==============================
// LC4 ISA definitions
// Word and field types, kept opcodes,
// two views of the instruction word, reset PC
//==============================
`default_nettype none

package lc4_isa_pkg;

   typedef logic [15:0] lc4_word_t;
   typedef logic [2:0]  lc4_rsel_t;
   typedef logic [2:0]  lc4_nzp_t;    // N, Z, P from msb down

   typedef enum logic [3:0] {
      op_br    = 4'b0000,
      op_arith = 4'b0001,
      op_logic = 4'b0101,
      op_ldr   = 4'b0110,
      op_str   = 4'b0111,
      op_const = 4'b1001
   } lc4_opcode_e;

   // Register-register sub-ops, bit 5 of the word is clear for both
   localparam logic [2:0] sub_add = 3'b000;
   localparam logic [2:0] sub_and = 3'b000;

   typedef struct packed {
      logic [3:0] opcode;
      lc4_rsel_t  rd;
      lc4_rsel_t  rs;
      logic [2:0] subop;
      lc4_rsel_t  rt;
   } lc4_insn_r_t;

   // imm9 holds rs over imm6, and the imm-select bit over imm5
   typedef struct packed {
      logic [3:0] opcode;
      logic [2:0] rd;                 // nzp mask for BR
      logic [8:0] imm9;
   } lc4_insn_i_t;

   typedef union packed {
      lc4_insn_r_t rtype;
      lc4_insn_i_t itype;
   } lc4_insn_u;

   localparam lc4_word_t lc4_reset_pc = 16'h8200;

endpackage

`default_nettype wire

// ==== rtl/lc4_pipe_pkg.sv ====
//==============================
// Pipeline records
// ALU op encoding, decoded control record,
// D/X, X/M and M/W stage records
//==============================
`default_nettype none

package lc4_pipe_pkg;
   import lc4_isa_pkg::*;

   typedef enum logic [2:0] {
      alu_add,
      alu_addi,
      alu_and,
      alu_const,
      alu_addr,                        // Base plus imm6 for LDR and STR
      alu_brt                          // Branch target
   } lc4_alu_op_e;

   // All zero is a bubble
   typedef struct packed {
      lc4_rsel_t   rs;
      lc4_rsel_t   rt;
      lc4_rsel_t   rd;
      logic        rs_re;
      logic        rt_re;
      logic        rf_we;
      logic        nzp_we;
      logic        is_load;
      logic        is_store;
      logic        is_branch;
      lc4_nzp_t    br_mask;
      lc4_alu_op_e alu_op;
   } lc4_ctrl_t;

   typedef struct packed {
      lc4_ctrl_t ctrl;
      lc4_insn_u insn;
      lc4_word_t pc_plus1;
      lc4_word_t rs_data;
      lc4_word_t rt_data;
   } lc4_x_t;

   typedef struct packed {
      logic      rf_we;
      lc4_rsel_t rd;
      logic      is_load;
      logic      is_store;
      lc4_word_t result;              // Also the data address
      lc4_word_t st_data;
   } lc4_m_t;

   typedef struct packed {
      logic      rf_we;
      lc4_rsel_t rd;
      logic      is_load;
      lc4_word_t result;
      lc4_word_t ld_data;
   } lc4_w_t;

endpackage

`default_nettype wire

// ==== rtl/lc4_fetch.sv ====
//==============================
// Fetch stage
// Program counter and F/D register
//==============================
`timescale 1ns/1ps
`default_nettype none

module lc4_fetch #(
   parameter lc4_isa_pkg::lc4_word_t p_reset_pc = lc4_isa_pkg::lc4_reset_pc
) (
   input  logic                   gwe,
   input  logic                   i_arst_n,
   input  lc4_isa_pkg::lc4_word_t i_imem_data,
   input  logic                   i_stall,
   input  logic                   i_flush,
   input  lc4_isa_pkg::lc4_word_t i_target,
   output lc4_isa_pkg::lc4_word_t o_imem_addr,
   output lc4_isa_pkg::lc4_insn_u o_insn,
   output lc4_isa_pkg::lc4_word_t o_pc_plus1
);
   import lc4_isa_pkg::*;

   lc4_word_t pc_q;
   lc4_word_t pc_plus1;

   assign pc_plus1    = pc_q + 16'd1;
   assign o_imem_addr = pc_q;

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc_q       <= p_reset_pc;
         o_insn     <= '0;            // All-zero word decodes as NOP
         o_pc_plus1 <= '0;
      end else if (i_flush) begin
         pc_q       <= i_target;      // Redirect from X
         o_insn     <= '0;
      end else if (!i_stall) begin
         pc_q       <= pc_plus1;
         o_insn     <= i_imem_data;
         o_pc_plus1 <= pc_plus1;
      end
   end

   // First fetch after reset comes from the reset vector
   a_reset_pc: assert property (@(posedge gwe) !i_arst_n ##1 i_arst_n |->
                                o_imem_addr == p_reset_pc)
      else $error("first fetch address %h is not the reset PC", o_imem_addr);

endmodule

`default_nettype wire

// ==== rtl/lc4_decoder.sv ====
//==============================
// Instruction decoder
// D-stage word to control record
//==============================
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder (
   input  lc4_isa_pkg::lc4_insn_u  i_insn,
   output lc4_pipe_pkg::lc4_ctrl_t o_ctrl
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   logic alu_wr;    // ADD, AND or CONST writing rd and NZP
   logic rr_form;   // Register form, reads rt

   always_comb begin
      o_ctrl  = '0;
      alu_wr  = 1'b0;
      rr_form = 1'b0;
      case (lc4_opcode_e'(i_insn.rtype.opcode))
         op_br: begin
            if (i_insn.itype.rd != 3'b000) begin      // Empty mask stays a NOP
               o_ctrl.is_branch = 1'b1;
               o_ctrl.br_mask   = i_insn.itype.rd;
               o_ctrl.alu_op    = alu_brt;
            end
         end
         op_arith: begin
            if (i_insn.itype.imm9[5]) begin
               alu_wr        = 1'b1;
               o_ctrl.alu_op = alu_addi;
            end else if (i_insn.rtype.subop == sub_add) begin
               alu_wr        = 1'b1;
               rr_form       = 1'b1;
               o_ctrl.alu_op = alu_add;
            end
         end
         op_logic: begin
            if (i_insn.rtype.subop == sub_and) begin
               alu_wr        = 1'b1;
               rr_form       = 1'b1;
               o_ctrl.alu_op = alu_and;
            end
         end
         op_ldr: begin
            o_ctrl.rs      = i_insn.rtype.rs;
            o_ctrl.rs_re   = 1'b1;
            o_ctrl.rd      = i_insn.rtype.rd;
            o_ctrl.rf_we   = 1'b1;
            o_ctrl.is_load = 1'b1;
            o_ctrl.alu_op  = alu_addr;
         end
         op_str: begin
            o_ctrl.rs       = i_insn.rtype.rs;
            o_ctrl.rs_re    = 1'b1;
            o_ctrl.rt       = i_insn.rtype.rd;          // Stored value sits in bits 11:9
            o_ctrl.rt_re    = 1'b1;
            o_ctrl.is_store = 1'b1;
            o_ctrl.alu_op   = alu_addr;
         end
         op_const: begin
            o_ctrl.rd     = i_insn.rtype.rd;
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.alu_op = alu_const;
         end
         default: ;                                      // Unsupported, bubble
      endcase
      if (alu_wr) begin
         o_ctrl.rs     = i_insn.rtype.rs;
         o_ctrl.rs_re  = 1'b1;
         o_ctrl.rd     = i_insn.rtype.rd;
         o_ctrl.rf_we  = 1'b1;
         o_ctrl.nzp_we = 1'b1;
      end
      if (rr_form) begin
         o_ctrl.rt    = i_insn.rtype.rt;
         o_ctrl.rt_re = 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/lc4_regfile.sv ====
//==============================
// Register file
// Eight registers, write-through reads
//==============================
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile (
   input  logic                   gwe,
   input  logic                   i_arst_n,
   input  lc4_isa_pkg::lc4_rsel_t i_rs,
   input  lc4_isa_pkg::lc4_rsel_t i_rt,
   input  logic                   i_we,
   input  lc4_isa_pkg::lc4_rsel_t i_wsel,
   input  lc4_isa_pkg::lc4_word_t i_wdata,
   output lc4_isa_pkg::lc4_word_t o_rs_data,
   output lc4_isa_pkg::lc4_word_t o_rt_data
);
   import lc4_isa_pkg::*;

   lc4_word_t regs_q [8];

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         regs_q <= '{default: '0};
      end else if (i_we) begin
         regs_q[i_wsel] <= i_wdata;
      end
   end

   // W writes in the same cycle D reads
   assign o_rs_data = (i_we && i_wsel == i_rs) ? i_wdata : regs_q[i_rs];
   assign o_rt_data = (i_we && i_wsel == i_rt) ? i_wdata : regs_q[i_rt];

   a_known_read: assert property (@(posedge gwe) disable iff (!i_arst_n)
                                  !$isunknown({o_rs_data, o_rt_data}))
      else $error("register read returns unknown data");

endmodule

`default_nettype wire

// ==== rtl/lc4_hazard_unit.sv ====
//==============================
// Hazard unit
// Load-to-use stall, branch flush,
// X-stage bypass selects
//==============================
`timescale 1ns/1ps
`default_nettype none

module lc4_hazard_unit (
   input  lc4_pipe_pkg::lc4_ctrl_t i_d_ctrl,
   input  lc4_pipe_pkg::lc4_ctrl_t i_x_ctrl,
   input  lc4_isa_pkg::lc4_rsel_t  i_m_rd,
   input  lc4_isa_pkg::lc4_rsel_t  i_w_rd,
   input  logic                    i_m_we,
   input  logic                    i_m_load,
   input  logic                    i_w_we,
   input  logic                    i_take_branch,
   output logic                    o_stall,
   output logic                    o_flush,
   output logic [1:0]              o_rs_byp,    // 0 regfile, 1 M, 2 W
   output logic [1:0]              o_rt_byp
);
   logic d_rs_hit;
   logic d_rt_hit;
   logic m_rs_hit;
   logic m_rt_hit;
   logic w_rs_hit;
   logic w_rt_hit;

   // Store data in D is not a use, it gets bypassed later
   assign d_rs_hit = i_d_ctrl.rs_re && (i_d_ctrl.rs == i_x_ctrl.rd);
   assign d_rt_hit = i_d_ctrl.rt_re && !i_d_ctrl.is_store && (i_d_ctrl.rt == i_x_ctrl.rd);

   assign o_flush = i_take_branch;
   assign o_stall = i_x_ctrl.is_load && (d_rs_hit || d_rt_hit) && !i_take_branch;

   // A load in M only feeds a store's data, the stall covers other uses
   assign m_rs_hit = i_m_we && !i_m_load && (i_m_rd == i_x_ctrl.rs);
   assign m_rt_hit = i_m_we && (!i_m_load || i_x_ctrl.is_store) && (i_m_rd == i_x_ctrl.rt);
   assign w_rs_hit = i_w_we && (i_w_rd == i_x_ctrl.rs);
   assign w_rt_hit = i_w_we && (i_w_rd == i_x_ctrl.rt);

   assign o_rs_byp = !i_x_ctrl.rs_re ? 2'd0 : m_rs_hit ? 2'd1 : w_rs_hit ? 2'd2 : 2'd0;
   assign o_rt_byp = !i_x_ctrl.rt_re ? 2'd0 : m_rt_hit ? 2'd1 : w_rt_hit ? 2'd2 : 2'd0;

   always_comb begin
      if (o_stall || o_flush) begin
         a_cause: assert (i_x_ctrl.is_load || i_x_ctrl.is_branch)
            else $error("stall or flush with no load or branch in X");
      end
   end

endmodule

`default_nettype wire

// ==== rtl/lc4_alu.sv ====
//==============================
// ALU
// Arithmetic, memory address and
// branch target
//==============================
`timescale 1ns/1ps
`default_nettype none

module lc4_alu (
   input  lc4_pipe_pkg::lc4_alu_op_e i_op,
   input  lc4_isa_pkg::lc4_insn_u    i_insn,
   input  lc4_isa_pkg::lc4_word_t    i_pc_plus1,
   input  lc4_isa_pkg::lc4_word_t    i_a,
   input  lc4_isa_pkg::lc4_word_t    i_b,
   output lc4_isa_pkg::lc4_word_t    o_result
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   lc4_word_t imm5_sx;
   lc4_word_t imm6_sx;
   lc4_word_t imm9_sx;

   // All three immediates share the low bits of imm9
   assign imm5_sx = {{11{i_insn.itype.imm9[4]}}, i_insn.itype.imm9[4:0]};
   assign imm6_sx = {{10{i_insn.itype.imm9[5]}}, i_insn.itype.imm9[5:0]};
   assign imm9_sx = {{7{i_insn.itype.imm9[8]}}, i_insn.itype.imm9};

   always_comb begin
      case (i_op)
         alu_add:   o_result = i_a + i_b;
         alu_addi:  o_result = i_a + imm5_sx;
         alu_and:   o_result = i_a & i_b;
         alu_const: o_result = imm9_sx;
         alu_addr:  o_result = i_a + imm6_sx;
         alu_brt:   o_result = i_pc_plus1 + imm9_sx;   // PC-relative
         default:   o_result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/lc4_core.sv ====
//==============================
// LC4 five-stage core
// D/X, X/M, M/W records, NZP, bypass,
// memory and write-back ports
//==============================
`timescale 1ns/1ps
`default_nettype none

module lc4_core #(
   parameter lc4_isa_pkg::lc4_word_t p_reset_pc = lc4_isa_pkg::lc4_reset_pc
) (
   input  logic                   gwe,
   input  logic                   i_arst_n,
   input  lc4_isa_pkg::lc4_word_t i_imem_data,
   input  lc4_isa_pkg::lc4_word_t i_dmem_rdata,
   output lc4_isa_pkg::lc4_word_t o_imem_addr,
   output lc4_isa_pkg::lc4_word_t o_dmem_addr,
   output lc4_isa_pkg::lc4_word_t o_dmem_wdata,
   output logic                   o_dmem_we,
   output logic                   o_wb_we,
   output lc4_isa_pkg::lc4_rsel_t o_wb_sel,
   output lc4_isa_pkg::lc4_word_t o_wb_data
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   lc4_insn_u  d_insn;
   lc4_word_t  d_pc_plus1;
   lc4_ctrl_t  d_ctrl;
   lc4_word_t  d_rs_data;
   lc4_word_t  d_rt_data;
   logic       stall;
   logic       flush;
   logic [1:0] rs_byp;
   logic [1:0] rt_byp;
   lc4_x_t     x_q;
   lc4_m_t     m_q;
   lc4_w_t     w_q;
   lc4_nzp_t   nzp_q;
   lc4_nzp_t   nzp_new;
   lc4_word_t  x_a;
   lc4_word_t  x_b;
   lc4_word_t  x_result;
   lc4_word_t  m_fwd;
   lc4_word_t  wb_data;
   logic       take_branch;

   lc4_fetch #(.p_reset_pc(p_reset_pc)) u_fetch (
      .gwe(gwe), .i_arst_n(i_arst_n), .i_imem_data(i_imem_data),
      .i_stall(stall), .i_flush(flush), .i_target(x_result),
      .o_imem_addr(o_imem_addr), .o_insn(d_insn), .o_pc_plus1(d_pc_plus1)
   );

   lc4_decoder u_decoder (.i_insn(d_insn), .o_ctrl(d_ctrl));

   lc4_regfile u_regfile (
      .gwe(gwe), .i_arst_n(i_arst_n), .i_rs(d_ctrl.rs), .i_rt(d_ctrl.rt),
      .i_we(w_q.rf_we), .i_wsel(w_q.rd), .i_wdata(wb_data),
      .o_rs_data(d_rs_data), .o_rt_data(d_rt_data)
   );

   lc4_hazard_unit u_hazard (
      .i_d_ctrl(d_ctrl), .i_x_ctrl(x_q.ctrl), .i_m_rd(m_q.rd), .i_w_rd(w_q.rd),
      .i_m_we(m_q.rf_we), .i_m_load(m_q.is_load), .i_w_we(w_q.rf_we),
      .i_take_branch(take_branch), .o_stall(stall), .o_flush(flush),
      .o_rs_byp(rs_byp), .o_rt_byp(rt_byp)
   );

   lc4_alu u_alu (
      .i_op(x_q.ctrl.alu_op), .i_insn(x_q.insn), .i_pc_plus1(x_q.pc_plus1),
      .i_a(x_a), .i_b(x_b), .o_result(x_result)
   );

   assign m_fwd   = m_q.is_load ? i_dmem_rdata : m_q.result;   // Load data reaches store data only
   assign wb_data = w_q.is_load ? w_q.ld_data : w_q.result;

   always_comb begin
      case (rs_byp)
         2'd1:    x_a = m_fwd;
         2'd2:    x_a = wb_data;
         default: x_a = x_q.rs_data;
      endcase
      case (rt_byp)
         2'd1:    x_b = m_fwd;
         2'd2:    x_b = wb_data;
         default: x_b = x_q.rt_data;
      endcase
   end

   // Only ALU ops write NZP, so the register is current for a branch in X
   assign nzp_new     = x_result[15] ? 3'b100 : (x_result == '0) ? 3'b010 : 3'b001;
   assign take_branch = x_q.ctrl.is_branch && |(x_q.ctrl.br_mask & nzp_q);

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         x_q   <= '0;
         m_q   <= '0;
         w_q   <= '0;
         nzp_q <= '0;
      end else begin
         if (stall || flush) begin
            x_q.ctrl <= '0;                     // Bubble into X
         end else begin
            x_q.ctrl <= d_ctrl;
         end
         x_q.insn     <= d_insn;
         x_q.pc_plus1 <= d_pc_plus1;
         x_q.rs_data  <= d_rs_data;
         x_q.rt_data  <= d_rt_data;
         if (x_q.ctrl.nzp_we) begin
            nzp_q <= nzp_new;
         end
         m_q.rf_we    <= x_q.ctrl.rf_we;
         m_q.rd       <= x_q.ctrl.rd;
         m_q.is_load  <= x_q.ctrl.is_load;
         m_q.is_store <= x_q.ctrl.is_store;
         m_q.result   <= x_result;
         m_q.st_data  <= x_b;
         w_q.rf_we    <= m_q.rf_we;
         w_q.rd       <= m_q.rd;
         w_q.is_load  <= m_q.is_load;
         w_q.result   <= m_q.result;
         w_q.ld_data  <= i_dmem_rdata;
      end
   end

   assign o_dmem_addr  = m_q.result;
   assign o_dmem_we    = m_q.is_store;
   assign o_dmem_wdata = m_q.st_data;
   assign o_wb_we      = w_q.rf_we;
   assign o_wb_sel     = w_q.rd;
   assign o_wb_data    = wb_data;

endmodule

`default_nettype wire

// ==== tb/lc4_mem_model.sv ====
//==============================
// Memory models for the LC4 core
// Instruction memory with load tasks,
// data memory with address-based fill
//==============================
`timescale 1ns/1ps
`default_nettype none

module lc4_mem_model (
   input  logic                   gwe,
   input  lc4_isa_pkg::lc4_word_t i_imem_addr,
   output lc4_isa_pkg::lc4_word_t o_imem_data,
   input  lc4_isa_pkg::lc4_word_t i_dmem_addr,
   input  logic                   i_dmem_we,
   input  lc4_isa_pkg::lc4_word_t i_dmem_wdata,
   output lc4_isa_pkg::lc4_word_t o_dmem_rdata
);
   import lc4_isa_pkg::*;

   lc4_word_t imem [65536];
   lc4_word_t dmem [65536];

   // Both ports answer in the same cycle
   assign o_imem_data  = imem[i_imem_addr];
   assign o_dmem_rdata = dmem[i_dmem_addr];

   // Byte-swapped address, so every word differs from its neighbours
   initial begin
      int a;
      for (a = 0; a < 65536; a++) begin
         dmem[a] <= {a[7:0], a[15:8]} ^ 16'h3c5a;
      end
   end

   always @(posedge gwe) begin
      if (i_dmem_we) begin
         dmem[i_dmem_addr] <= i_dmem_wdata;
      end
   end

   // Zero words decode as NOP
   task automatic clear_imem;
      int a;
      for (a = 0; a < 65536; a++) begin
         imem[a] = '0;
      end
   endtask

   task automatic write_insn(input lc4_word_t addr, input lc4_word_t word);
      imem[addr] = word;
   endtask

endmodule

`default_nettype wire

// ==== tb/lc4_core_tb.sv ====
//==============================
// Testbench for the LC4 core
// Clock, reset, ISA reference model,
// directed tests, checks, watchdog
//==============================
`timescale 1ns/1ps
`default_nettype none

module lc4_core_tb;
   import lc4_isa_pkg::*;

   localparam lc4_word_t reset_pc = 16'h8200;

   logic      gwe;
   logic      arst_n;
   lc4_word_t imem_addr;
   lc4_word_t imem_data;
   lc4_word_t dmem_addr;
   lc4_word_t dmem_wdata;
   lc4_word_t dmem_rdata;
   logic      dmem_we;
   logic      wb_we;
   lc4_rsel_t wb_sel;
   lc4_word_t wb_data;

   int     errors      = 0;
   int     checks      = 0;
   int     cycle_count = 0;
   int     cycle_limit = 1000;
   integer seed;

   logic [15:0] prog [$];             // Program words from reset_pc upward
   logic [2:0]  exp_sel [$];
   logic [15:0] exp_wb [$];
   logic [15:0] exp_st_addr [$];
   logic [15:0] exp_st_data [$];
   logic [15:0] st_addrs [$];
   logic [15:0] ref_dmem [logic [15:0]];   // Stored words survive from one test to the next

   lc4_mem_model u_mem (
      .gwe(gwe), .i_imem_addr(imem_addr), .o_imem_data(imem_data),
      .i_dmem_addr(dmem_addr), .i_dmem_we(dmem_we), .i_dmem_wdata(dmem_wdata),
      .o_dmem_rdata(dmem_rdata)
   );

   lc4_core #(.p_reset_pc(reset_pc)) u_lc4_core (
      .gwe(gwe), .i_arst_n(arst_n), .i_imem_data(imem_data), .i_dmem_rdata(dmem_rdata),
      .o_imem_addr(imem_addr), .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata),
      .o_dmem_we(dmem_we), .o_wb_we(wb_we), .o_wb_sel(wb_sel), .o_wb_data(wb_data)
   );

   initial begin
      gwe = 1'b0;
      forever #4 gwe = ~gwe;
   end

   // Watchdog limit moves forward with each program
   always @(posedge gwe) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("Timeout: expected write-backs or stores never appeared by cycle %0d",
                  cycle_count);
         $display("Checks run: %0d, errors: %0d", checks, errors + 1);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   function automatic logic [15:0] sign_extend(input logic [15:0] v, input int bits);
      logic [15:0] r;
      int          i;
      r = v;
      for (i = bits; i < 16; i++) begin
         r[i] = v[bits-1];
      end
      return r;
   endfunction

   function automatic logic [15:0] dmem_init_word(input logic [15:0] addr);
      return {addr[7:0], addr[15:8]} ^ 16'h3c5a;
   endfunction

   function automatic logic [15:0] const_insn(input int rd, input int imm);
      return {4'b1001, rd[2:0], imm[8:0]};
   endfunction

   function automatic logic [15:0] add_insn(input int rd, input int rs, input int rt);
      return {4'b0001, rd[2:0], rs[2:0], 3'b000, rt[2:0]};
   endfunction

   function automatic logic [15:0] addi_insn(input int rd, input int rs, input int imm);
      return {4'b0001, rd[2:0], rs[2:0], 1'b1, imm[4:0]};
   endfunction

   function automatic logic [15:0] and_insn(input int rd, input int rs, input int rt);
      return {4'b0101, rd[2:0], rs[2:0], 3'b000, rt[2:0]};
   endfunction

   function automatic logic [15:0] ldr_insn(input int rd, input int rs, input int imm);
      return {4'b0110, rd[2:0], rs[2:0], imm[5:0]};
   endfunction

   function automatic logic [15:0] str_insn(input int rt, input int rs, input int imm);
      return {4'b0111, rt[2:0], rs[2:0], imm[5:0]};
   endfunction

   function automatic logic [15:0] br_insn(input int mask, input int off);
      return {4'b0000, mask[2:0], off[8:0]};
   endfunction

   task automatic compare_word(input string sig, input logic [15:0] expv,
                               input logic [15:0] got);
      checks++;
      if (got !== expv) begin
         errors++;
         $display("ERROR at %0t ns: %s expected %h got %h", $time, sig, expv, got);
      end
   endtask

   // Sequential ISA model that fills the expected write-back and store streams
   task automatic model_program;
      logic [15:0] rf [8];
      logic [15:0] pc;
      logic [15:0] w;
      logic [15:0] addr;
      logic [15:0] val;
      logic [2:0]  nzp;
      logic        alu_wr;
      int          r;
      int          idx;
      int          steps;
      for (r = 0; r < 8; r++) begin
         rf[r] = '0;
      end
      exp_sel.delete();
      exp_wb.delete();
      exp_st_addr.delete();
      exp_st_data.delete();
      st_addrs.delete();
      pc    = reset_pc;
      nzp   = 3'b000;
      idx   = 0;
      steps = 0;
      while (idx < prog.size() && steps < 4 * prog.size()) begin
         w      = prog[idx];
         pc     = pc + 16'd1;
         alu_wr = 1'b0;
         case (w[15:12])
            4'b0000: begin
               if ((w[11:9] & nzp) != 3'b000) begin
                  pc = pc + sign_extend({7'b0, w[8:0]}, 9);
               end
            end
            4'b0001: begin
               if (w[5]) begin
                  val    = rf[w[8:6]] + sign_extend({11'b0, w[4:0]}, 5);
                  alu_wr = 1'b1;
               end else if (w[5:3] == 3'b000) begin
                  val    = rf[w[8:6]] + rf[w[2:0]];
                  alu_wr = 1'b1;
               end
            end
            4'b0101: begin
               if (w[5:3] == 3'b000) begin
                  val    = rf[w[8:6]] & rf[w[2:0]];
                  alu_wr = 1'b1;
               end
            end
            4'b0110: begin
               addr = rf[w[8:6]] + sign_extend({10'b0, w[5:0]}, 6);
               val  = ref_dmem.exists(addr) ? ref_dmem[addr] : dmem_init_word(addr);
               rf[w[11:9]] = val;                     // Loads leave NZP alone
               exp_sel.push_back(w[11:9]);
               exp_wb.push_back(val);
            end
            4'b0111: begin
               addr = rf[w[8:6]] + sign_extend({10'b0, w[5:0]}, 6);
               ref_dmem[addr] = rf[w[11:9]];
               exp_st_addr.push_back(addr);
               exp_st_data.push_back(rf[w[11:9]]);
               st_addrs.push_back(addr);
            end
            4'b1001: begin
               val    = sign_extend({7'b0, w[8:0]}, 9);
               alu_wr = 1'b1;
            end
            default: ;
         endcase
         if (alu_wr) begin
            rf[w[11:9]] = val;
            nzp = val[15] ? 3'b100 : (val == 16'h0000) ? 3'b010 : 3'b001;
            exp_sel.push_back(w[11:9]);
            exp_wb.push_back(val);
         end
         idx = int'(pc - reset_pc);
         steps++;
      end
   endtask

   task automatic check_no_writes;
      compare_word("o_wb_we", 16'h0000, {15'b0, wb_we});
      compare_word("o_dmem_we", 16'h0000, {15'b0, dmem_we});
   endtask

   task automatic check_reset_outputs;
      compare_word("o_imem_addr", reset_pc, imem_addr);
      check_no_writes();
   endtask

   // Called at the falling edge, when all DUT outputs are settled
   task automatic sample_outputs;
      if (wb_we) begin
         if (exp_sel.size() == 0) begin
            errors++;
            $display("Unexpected write-back to R%0d with data %h at %0t ns",
                     wb_sel, wb_data, $time);
         end else begin
            compare_word("o_wb_sel", {13'b0, exp_sel.pop_front()}, {13'b0, wb_sel});
            compare_word("o_wb_data", exp_wb.pop_front(), wb_data);
         end
      end
      if (dmem_we) begin
         if (exp_st_addr.size() == 0) begin
            errors++;
            $display("Unexpected store of %h to address %h at %0t ns",
                     dmem_wdata, dmem_addr, $time);
         end else begin
            compare_word("o_dmem_addr", exp_st_addr.pop_front(), dmem_addr);
            compare_word("o_dmem_wdata", exp_st_data.pop_front(), dmem_wdata);
         end
      end
   endtask

   task automatic execute_program(input string name);
      int i;
      model_program();
      cycle_limit = cycle_count + 40 * prog.size();
      @(posedge gwe);
      arst_n <= 1'b0;
      @(negedge gwe);
      u_mem.clear_imem();                      // Loaded while the core sits in reset
      for (i = 0; i < prog.size(); i++) begin
         u_mem.write_insn(reset_pc + 16'(i), prog[i]);
      end
      check_reset_outputs();
      @(posedge gwe);
      @(negedge gwe);
      check_reset_outputs();
      @(posedge gwe);
      arst_n <= 1'b1;
      @(negedge gwe);
      compare_word("o_imem_addr", reset_pc, imem_addr);
      // The first instruction takes four edges to reach W
      for (i = 0; i < 4; i++) begin
         check_no_writes();
         @(negedge gwe);
      end
      compare_word("o_wb_we", 16'h0001, {15'b0, wb_we});   // Every program opens with a register write
      sample_outputs();
      while (exp_sel.size() > 0 || exp_st_addr.size() > 0) begin
         @(negedge gwe);
         sample_outputs();
      end
      // Flushed or stray instructions would show up here
      repeat (8) begin
         @(negedge gwe);
         sample_outputs();
      end
      for (i = 0; i < st_addrs.size(); i++) begin
         compare_word("data memory word", ref_dmem[st_addrs[i]], u_mem.dmem[st_addrs[i]]);
      end
      $display("Finished %s", name);
   endtask

   task automatic alu_chain_test;
      prog.delete();
      prog.push_back(const_insn(1, 5));
      prog.push_back(const_insn(2, -3));
      prog.push_back(add_insn(3, 1, 2));       // R2 from M, R1 from W
      prog.push_back(addi_insn(4, 3, 7));
      prog.push_back(and_insn(5, 4, 1));
      prog.push_back(add_insn(6, 3, 5));       // R3 through the register file
      prog.push_back(addi_insn(7, 7, -1));
      prog.push_back(and_insn(0, 6, 2));
      prog.push_back(add_insn(1, 1, 1));
      execute_program("ALU dependency chain");
   endtask

   task automatic store_load_test;
      prog.delete();
      prog.push_back(const_insn(1, 16'h40));
      prog.push_back(const_insn(2, 123));
      prog.push_back(str_insn(2, 1, 3));
      prog.push_back(ldr_insn(3, 1, 3));
      prog.push_back(add_insn(4, 3, 3));       // Load-to-use stall
      prog.push_back(ldr_insn(5, 1, 4));
      prog.push_back(str_insn(5, 1, 5));       // Load data straight into store data
      prog.push_back(addi_insn(6, 5, 1));
      prog.push_back(ldr_insn(7, 1, 5));
      execute_program("store and load");
   endtask

   task automatic branch_test;
      prog.delete();
      prog.push_back(const_insn(1, -4));
      prog.push_back(br_insn(3'b011, 1));      // Not taken on N
      prog.push_back(br_insn(3'b100, 2));      // Taken on N
      prog.push_back(const_insn(2, 1));
      prog.push_back(const_insn(3, 2));
      prog.push_back(const_insn(4, 0));
      prog.push_back(br_insn(3'b101, 1));      // Not taken on Z
      prog.push_back(const_insn(5, 9));
      prog.push_back(br_insn(3'b010, 2));
      prog.push_back(br_insn(3'b001, 2));      // Taken on P
      prog.push_back(const_insn(6, 3));
      prog.push_back(const_insn(7, 4));
      prog.push_back(add_insn(0, 5, 1));
      prog.push_back(const_insn(2, 0));
      prog.push_back(br_insn(3'b010, 1));
      prog.push_back(const_insn(3, 7));
      prog.push_back(addi_insn(3, 3, 2));
      execute_program("branches");
   endtask

   task automatic random_alu_test;
      int k;
      int rnd;
      int kind;
      prog.delete();
      for (k = 0; k < 30; k++) begin
         rnd  = $random(seed);
         kind = rnd & 3;
         if (kind == 1) begin
            prog.push_back(add_insn((rnd >> 2) & 7, (rnd >> 5) & 7, (rnd >> 8) & 7));
         end else if (kind == 2) begin
            prog.push_back(and_insn((rnd >> 2) & 7, (rnd >> 5) & 7, (rnd >> 8) & 7));
         end else begin
            prog.push_back(const_insn((rnd >> 2) & 7, rnd >> 11));
         end
      end
      execute_program("random ALU sequence");
   endtask

   initial begin
      arst_n <= 1'b0;
      seed = 34499;
      alu_chain_test();
      store_load_test();
      branch_test();
      random_alu_test();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/lc4_isa_pkg.sv
rtl/lc4_pipe_pkg.sv
rtl/lc4_fetch.sv
rtl/lc4_decoder.sv
rtl/lc4_regfile.sv
rtl/lc4_hazard_unit.sv
rtl/lc4_alu.sv
rtl/lc4_core.sv
tb/lc4_mem_model.sv
tb/lc4_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the LC4 core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f vlog.f --top-module lc4_core_tb \
   -Mdir "$build_dir" -o lc4_core_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$build_dir/lc4_core_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "SIMULATION PASSED" "$log_file"; then
   exit 0
fi
echo "Pass message not found in $log_file"
exit 1
